/* files.f */
src/cpu_pkg.sv
src/board_pkg.sv
src/sequencer.sv
src/fetch_unit.sv
src/reg_file.sv
src/alu.sv
src/display_select.sv
src/chip_interface.sv
tests/chip_interface_asserts.sv
tests/chip_interface_tb.sv

/* tests/chip_interface_tb.sv */
`timescale 1ns/1ns

module chip_interface_tb;
	import cpu_pkg::*;
	import board_pkg::*;

	localparam int NUM_ROWS    = 13;
	localparam int PROG_BYTES  = 16;
	localparam int RESET_CYC   = 5;
	localparam int HOLD_CYC    = 10; // run stays low this long in the gating row
	// three cycles per program byte plus reset and display checks for each row
	localparam int CYCLE_LIMIT = NUM_ROWS * (PROG_BYTES * 3 + 20);

	// one program and the register contents it must leave behind
	typedef struct packed {
		logic                    hold_run; // keep run low for a while after reset
		logic [PROG_BYTES*8-1:0] prog;     // byte 0 sits in the top bits
		data_t                   a, b, c, d, e, f, h, l;
	} row_t;

	logic      clk = 1'b0;
	logic      rst_n = 1'b0;
	logic      run = 1'b0;
	pair_sel_t reg_sel = '0;
	data_t     rom_data;
	addr_t     rom_addr;
	logic      halted;
	hex_t      hex;

	row_t  rows [NUM_ROWS];
	data_t rom [PROG_BYTES];   // program store, anything past it reads as halt
	int    cycle_count = 0;

	chip_interface chip_interface_i (.clk, .rst_n, .run, .reg_sel, .rom_data, .rom_addr,
		.halted, .hex);

	always #5 clk = ~clk;

	assign rom_data = (rom_addr < PROG_BYTES) ? rom[rom_addr[3:0]] : 8'h76;

	// ========================================================================
	// helpers
	// ========================================================================

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
			fail_run($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, expected));
	endtask

	// lit segments with bit 0 as a, inverted at the end for the board digits
	function automatic seg_t digit_segments(input logic [3:0] nib);
		logic [6:0] lit;
		case (nib)
			4'h0: lit = 7'h3F;
			4'h1: lit = 7'h06;
			4'h2: lit = 7'h5B;
			4'h3: lit = 7'h4F;
			4'h4: lit = 7'h66;
			4'h5: lit = 7'h6D;
			4'h6: lit = 7'h7D;
			4'h7: lit = 7'h07;
			4'h8: lit = 7'h7F;
			4'h9: lit = 7'h67; // this font draws 9 without the bottom bar
			4'hA: lit = 7'h77;
			4'hB: lit = 7'h7C;
			4'hC: lit = 7'h39;
			4'hD: lit = 7'h5E;
			4'hE: lit = 7'h79;
			default: lit = 7'h71;
		endcase
		return ~lit;
	endfunction

	task automatic reset_and_load(input row_t row);
		@(posedge clk);
		#1;
		rst_n = 1'b0;
		run   = 1'b0;
		for (int i = 0; i < PROG_BYTES; i++)
			rom[i] = row.prog[PROG_BYTES*8-1-8*i -: 8];
		repeat (RESET_CYC) @(posedge clk);
		#1;
		rst_n = 1'b1;
		run   = ~row.hold_run;
	endtask

	// walk all four pairs and compare the digits, sampled mid cycle
	task automatic check_pairs(input row_t row);
		logic [3:0][15:0] pairs;
		data_t            hi, lo;
		hex_t             expected;
		pairs = {{row.h, row.l}, {row.e, row.f}, {row.c, row.d}, {row.a, row.b}};
		for (int sel = 0; sel < 4; sel++) begin
			@(posedge clk);
			#1;
			reg_sel  = pair_sel_t'(sel);
			{hi, lo} = pairs[sel];
			expected = {digit_segments(hi[7:4]), digit_segments(hi[3:0]),
				digit_segments(lo[7:4]), digit_segments(lo[3:0])};
			@(negedge clk);
			check_value($sformatf("hex[reg_sel=%0d]", sel), hex, expected);
		end
	endtask

	// ========================================================================
	// program table, expected order is a b c d e f h l
	// ========================================================================

	task automatic load_table();
		rows[0]  = '{1'b0, 128'h3E12_0634_0E56_1678_1E9A_26BC_2EDE_7600, // ld r,d8 everywhere
			8'h12, 8'h34, 8'h56, 8'h78, 8'h9A, 8'h00, 8'hBC, 8'hDE};
		rows[1]  = '{1'b0, 128'h3E5A_4748_515A_636C_06C3_7876_0000_0000, // chain of copies
			8'hC3, 8'hC3, 8'h5A, 8'h5A, 8'h5A, 8'h00, 8'h5A, 8'h5A};
		rows[2]  = '{1'b0, 128'h3E0F_0601_8076_0000_0000_0000_0000_0000, // half carry
			8'h10, 8'h01, 8'h00, 8'h00, 8'h00, 8'h20, 8'h00, 8'h00};
		rows[3]  = '{1'b0, 128'h3EFF_0E01_8176_0000_0000_0000_0000_0000, // wraps to zero
			8'h00, 8'h00, 8'h01, 8'h00, 8'h00, 8'hB0, 8'h00, 8'h00};
		rows[4]  = '{1'b0, 128'h3E00_1601_9276_0000_0000_0000_0000_0000, // borrow out
			8'hFF, 8'h00, 8'h00, 8'h01, 8'h00, 8'h70, 8'h00, 8'h00};
		rows[5]  = '{1'b0, 128'h3E3C_1E3C_9376_0000_0000_0000_0000_0000,
			8'h00, 8'h00, 8'h00, 8'h00, 8'h3C, 8'hC0, 8'h00, 8'h00};
		rows[6]  = '{1'b0, 128'h3EF0_063C_0E0F_A067_B16F_AF76_0000_0000, // and, or, xor a,a
			8'h00, 8'h3C, 8'h0F, 8'h00, 8'h00, 8'h80, 8'h30, 8'h3F};
		rows[7]  = '{1'b0, 128'h3E55_16AA_A276_0000_0000_0000_0000_0000,
			8'h00, 8'h00, 8'h00, 8'hAA, 8'h00, 8'hA0, 8'h00, 8'h00};
		rows[8]  = '{1'b0, 128'h3EFF_8726_FF3E_5AAC_7600_0000_0000_0000, // xor clears carry
			8'hA5, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'hFF, 8'h00};
		rows[9]  = '{1'b0, 128'h3EFF_8706_FF04_0E10_0D76_0000_0000_0000, // inc, dec keep c=1
			8'hFE, 8'h00, 8'h0F, 8'h00, 8'h00, 8'h70, 8'h00, 8'h00};
		rows[10] = '{1'b0, 128'h3EFF_3C0E_100D_7600_0000_0000_0000_0000, // same with c=0
			8'h00, 8'h00, 8'h0F, 8'h00, 8'h00, 8'h60, 8'h00, 8'h00};
		rows[11] = '{1'b0, 128'h3E0F_0601_8088_98B8_4670_8634_3536_9976, // all act as nop
			8'h10, 8'h01, 8'h00, 8'h00, 8'h00, 8'h20, 8'h00, 8'h00};
		rows[12] = '{1'b1, 128'h1E77_2E88_7600_0000_0000_0000_0000_0000,
			8'h00, 8'h00, 8'h00, 8'h00, 8'h77, 8'h00, 8'h00, 8'h88};
	endtask

	// ========================================================================
	// run control
	// ========================================================================

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > CYCLE_LIMIT)
			fail_run("the run went past its cycle limit before all programs finished");
	end

	always @(posedge clk) begin
		if (chip_interface_i.asserts_i.error_count != 0)
			fail_run("a bound assertion on chip_interface failed");
	end

	initial begin
		load_table();
		for (int r = 0; r < NUM_ROWS; r++) begin
			reset_and_load(rows[r]);
			if (rows[r].hold_run) begin
				repeat (HOLD_CYC) @(posedge clk);
				#1;
				check_value("rom_addr", rom_addr, 32'h0); // nothing fetched yet
				check_value("halted", halted, 32'h0);
				run = 1'b1;
			end
			while (!halted) begin // wait until the halt opcode has been taken
				@(posedge clk);
				#1;
			end
			check_pairs(rows[r]);
		end
		if (chip_interface_i.asserts_i.error_count == 0) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			fail_run("a bound assertion on chip_interface failed");
		end
	end

endmodule

/* tests/chip_interface_asserts.sv */
`timescale 1ns/1ns

module chip_interface_asserts (
	input logic                clk,
	input logic                rst_n,
	input logic                run,
	input logic                halted,
	input cpu_pkg::addr_t      rom_addr,
	input cpu_pkg::seq_state_t state,
	input logic                reg_we
);
	import cpu_pkg::*;

	int error_count = 0; // failed properties so far

	// once halted only reset brings the core back
	halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		halted |=> halted)
	else begin
		$error("halted fell without a reset");
		error_count++;
	end

	// no fetch happens in halt or while run holds the core before a fetch
	addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(halted || (!run && state == S_FETCH)) |=> $stable(rom_addr))
	else begin
		$error("rom_addr moved while the core was halted or held");
		error_count++;
	end

	exec_only_write: assert property (@(posedge clk) disable iff (!rst_n)
		(state != S_EXEC) |-> !reg_we)
	else begin
		$error("reg_we was high outside the execute state");
		error_count++;
	end

endmodule

bind chip_interface chip_interface_asserts asserts_i (
	.clk, .rst_n, .run, .halted, .rom_addr,
	.state(sequencer_i.state), .reg_we(ctrl.reg_we)
);

/* src/chip_interface.sv */
`timescale 1ns/1ns

module chip_interface (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 run,     // level, core waits before each fetch
	input  board_pkg::pair_sel_t reg_sel,
	input  cpu_pkg::data_t       rom_data,
	output cpu_pkg::addr_t       rom_addr,
	output logic                 halted,
	output board_pkg::hex_t      hex
);
	import cpu_pkg::*;

	ctrl_t  ctrl;              // control word from the sequencer
	data_t  opcode, imm;
	data_t  a_val, b_val, result;
	flags_t flags, new_flags;
	data_t  pair_hi, pair_lo;  // selected register pair for the digits

	// ========================================================================
	// control and datapath
	// ========================================================================

	sequencer sequencer_i (.clk, .rst_n, .run, .opcode, .ctrl, .halted);

	fetch_unit fetch_unit_i (.clk, .rst_n, .ctrl, .rom_data, .rom_addr, .opcode, .imm);

	reg_file reg_file_i (
		.clk, .rst_n, .ctrl, .imm, .result, .new_flags,
		.a_val, .b_val, .flags, .reg_sel, .pair_hi, .pair_lo
	);

	alu alu_i (
		.op(ctrl.alu_op), .a(a_val), .b(b_val), .flags_in(flags),
		.result, .flags_out(new_flags)
	);

	display_select display_select_i (.pair_hi, .pair_lo, .hex); // board digits

endmodule

/* src/display_select.sv */
`timescale 1ns/1ns

module display_select (
	input  cpu_pkg::data_t  pair_hi,
	input  cpu_pkg::data_t  pair_lo,
	output board_pkg::hex_t hex
);
	import board_pkg::*;

	// ========================================================================
	// nibble to segment decode
	// ========================================================================

	// standard hex font, codes already inverted for the common anode digits
	function automatic seg_t nibble_to_seg(input logic [3:0] nib);
		seg_t seg;
		unique case (nib)
			4'h0: seg = 7'h40;
			4'h1: seg = 7'h79;
			4'h2: seg = 7'h24;
			4'h3: seg = 7'h30;
			4'h4: seg = 7'h19;
			4'h5: seg = 7'h12;
			4'h6: seg = 7'h02;
			4'h7: seg = 7'h78;
			4'h8: seg = 7'h00; // every segment lit
			4'h9: seg = 7'h18;
			4'hA: seg = 7'h08;
			4'hB: seg = 7'h03; // lower case b
			4'hC: seg = 7'h46;
			4'hD: seg = 7'h21; // lower case d
			4'hE: seg = 7'h06;
			4'hF: seg = 7'h0E;
		endcase
		return seg;
	endfunction

	// first register on the left two digits, second on the right two
	always_comb begin
		hex.hex3 = nibble_to_seg(pair_hi[7:4]);
		hex.hex2 = nibble_to_seg(pair_hi[3:0]);
		hex.hex1 = nibble_to_seg(pair_lo[7:4]);
		hex.hex0 = nibble_to_seg(pair_lo[3:0]);
	end

endmodule

/* src/alu.sv */
`timescale 1ns/1ns

module alu (
	input  cpu_pkg::alu_op_t op,
	input  cpu_pkg::data_t   a,
	input  cpu_pkg::data_t   b,
	input  cpu_pkg::flags_t  flags_in,
	output cpu_pkg::data_t   result,
	output cpu_pkg::flags_t  flags_out
);
	import cpu_pkg::*;

	data_t      opnd;     // b, or the constant one for inc and dec
	logic [8:0] sum;      // bit 8 is the carry out of bit 7
	logic [8:0] diff;     // bit 8 is the borrow
	logic [4:0] sum_lo;   // bit 4 is the carry out of bit 3
	logic [4:0] diff_lo;  // bit 4 is the borrow from bit 4

	// inc and dec reuse the add and subtract paths with a fixed one
	assign opnd = (op == ALU_INC || op == ALU_DEC) ? data_t'(1) : b;

	assign sum     = {1'b0, a} + {1'b0, opnd};
	assign diff    = {1'b0, a} - {1'b0, opnd};
	assign sum_lo  = {1'b0, a[3:0]} + {1'b0, opnd[3:0]};
	assign diff_lo = {1'b0, a[3:0]} - {1'b0, opnd[3:0]};

	// ========================================================================
	// result and flag rules
	// ========================================================================

	always_comb begin
		result    = b;        // pass is the default, used by the loads
		flags_out = flags_in; // anything not set below keeps its value
		unique case (op)
			ALU_ADD, ALU_INC: begin
				result      = sum[7:0];
				flags_out.n = 1'b0;
				flags_out.h = sum_lo[4];
				if (op == ALU_ADD)
					flags_out.c = sum[8]; // inc leaves carry alone
			end
			ALU_SUB, ALU_DEC: begin
				result      = diff[7:0];
				flags_out.n = 1'b1;
				flags_out.h = diff_lo[4];
				if (op == ALU_SUB)
					flags_out.c = diff[8]; // dec leaves carry alone too
			end
			ALU_AND: begin
				result      = a & b;
				flags_out.n = 1'b0;
				flags_out.h = 1'b1; // and always sets half carry on this cpu
				flags_out.c = 1'b0;
			end
			ALU_XOR, ALU_OR: begin
				result      = (op == ALU_XOR) ? (a ^ b) : (a | b);
				flags_out.n = 1'b0;
				flags_out.h = 1'b0;
				flags_out.c = 1'b0;
			end
			ALU_PASS: ;
		endcase
		// zero follows the result for every op, loads never write it back
		flags_out.z = (result == '0);
	end

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ns

module reg_file (
	input  logic                clk,
	input  logic                rst_n,
	input  cpu_pkg::ctrl_t      ctrl,
	input  cpu_pkg::data_t      imm,
	input  cpu_pkg::data_t      result,
	input  cpu_pkg::flags_t     new_flags,
	output cpu_pkg::data_t      a_val,
	output cpu_pkg::data_t      b_val,
	output cpu_pkg::flags_t     flags,
	input  board_pkg::pair_sel_t reg_sel,
	output cpu_pkg::data_t      pair_hi,
	output cpu_pkg::data_t      pair_lo
);
	import cpu_pkg::*;
	import board_pkg::*;

	data_t  gpr [8]; // indexed by register code, slot 6 stays zero
	flags_t f_q;     // upper nibble of F, the low nibble is always zero
	logic   two_op;  // op reads the accumulator rather than dst

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 8; i++)
				gpr[i] <= '0;
			f_q <= '0;
		end else begin
			if (ctrl.reg_we && ctrl.dst != REG_HL_MEM)
				gpr[ctrl.dst] <= result;
			if (ctrl.flag_we)
				f_q <= new_flags;
		end
	end

	// inc and dec work on dst itself, the rest combine A with the operand
	assign two_op = ctrl.alu_op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_XOR, ALU_OR};
	assign a_val  = gpr[two_op ? REG_A : ctrl.dst];
	assign b_val  = ctrl.use_imm ? imm : gpr[ctrl.src]; // operand mux
	assign flags  = f_q;

	// ========================================================================
	// display readout
	// ========================================================================

	always_comb begin
		unique case (reg_sel)
			PAIR_AB: begin
				pair_hi = gpr[REG_A];
				pair_lo = gpr[REG_B];
			end
			PAIR_CD: begin
				pair_hi = gpr[REG_C];
				pair_lo = gpr[REG_D];
			end
			PAIR_EF: begin
				pair_hi = gpr[REG_E];
				pair_lo = {f_q, 4'h0}; // z n h c land in bits 7..4
			end
			PAIR_HL: begin
				pair_hi = gpr[REG_H];
				pair_lo = gpr[REG_L];
			end
		endcase
	end

endmodule

/* src/fetch_unit.sv */
`timescale 1ns/1ns

module fetch_unit (
	input  logic           clk,
	input  logic           rst_n,
	input  cpu_pkg::ctrl_t ctrl,
	input  cpu_pkg::data_t rom_data,
	output cpu_pkg::addr_t rom_addr,
	output cpu_pkg::data_t opcode,
	output cpu_pkg::data_t imm
);
	import cpu_pkg::*;

	addr_t pc;
	data_t op_q;  // opcode of the instruction in flight
	data_t imm_q; // second byte of ld r,d8

	// pc steps on either fetch, both kinds of byte come from the same rom
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc   <= '0;
			op_q <= OP_NOP;
		end else begin
			if (ctrl.fetch_op || ctrl.fetch_imm)
				pc <= pc + addr_t'(1);
			if (ctrl.fetch_op)
				op_q <= rom_data;
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.fetch_imm)
			imm_q <= rom_data; // data byte that follows an ld r,d8 opcode
	end

	assign rom_addr = pc; // rom answers within the same cycle

	// during the fetch cycle the sequencer sees the byte on the rom bus,
	// so it can pick the next state before the opcode register fills
	assign opcode = ctrl.fetch_op ? rom_data : op_q;
	assign imm    = imm_q;

endmodule

/* src/sequencer.sv */
`timescale 1ns/1ns

module sequencer (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           run,
	input  cpu_pkg::data_t opcode,
	output cpu_pkg::ctrl_t ctrl,
	output logic           halted
);
	import cpu_pkg::*;

	seq_state_t state, state_nxt;
	logic [1:0] grp;         // top two opcode bits
	reg_idx_t   fld_dst;     // middle field, destination or alu sub-op
	reg_idx_t   fld_src;     // low field, source or misc sub-op
	reg_idx_t   dec_dst;
	logic       dec_reg_we;
	logic       dec_flag_we;
	logic       dec_imm;     // instruction carries a second byte
	alu_op_t    dec_op;

	assign grp     = opcode[FLD_GRP_LSB +: 2];
	assign fld_dst = opcode[FLD_DST_LSB +: 3];
	assign fld_src = opcode[FLD_SRC_LSB +: 3];

	// ========================================================================
	// opcode decode
	// ========================================================================

	always_comb begin : decode
		dec_dst     = fld_dst;
		dec_reg_we  = 1'b0; // anything not matched below falls through as a nop
		dec_flag_we = 1'b0;
		dec_imm     = 1'b0;
		dec_op      = ALU_PASS;
		case (grp)
			GRP_MISC: begin
				// ld (hl),d8 still eats its data byte so the next opcode lines up
				dec_imm = (fld_src == LO_LD_IMM);
				if (fld_dst != REG_HL_MEM) begin
					case (fld_src)
						LO_INC: begin
							dec_reg_we  = 1'b1;
							dec_flag_we = 1'b1;
							dec_op      = ALU_INC;
						end
						LO_DEC: begin
							dec_reg_we  = 1'b1;
							dec_flag_we = 1'b1;
							dec_op      = ALU_DEC;
						end
						LO_LD_IMM: dec_reg_we = 1'b1; // pass the immediate through
						default: ;
					endcase
				end
			end
			GRP_LD: begin
				// halt also lands here with both fields at 6, so it never writes
				dec_reg_we = (fld_dst != REG_HL_MEM) && (fld_src != REG_HL_MEM);
			end
			GRP_ALU: begin
				dec_dst = REG_A; // every alu op lands in the accumulator
				if (fld_src != REG_HL_MEM) begin
					dec_reg_we  = 1'b1;
					dec_flag_we = 1'b1;
					case (fld_dst)
						AOP_ADD: dec_op = ALU_ADD;
						AOP_SUB: dec_op = ALU_SUB;
						AOP_AND: dec_op = ALU_AND;
						AOP_XOR: dec_op = ALU_XOR;
						AOP_OR:  dec_op = ALU_OR;
						default: begin // adc, sbc and cp are not built
							dec_reg_we  = 1'b0;
							dec_flag_we = 1'b0;
						end
					endcase
				end
			end
			default: ; // jumps, stack and the rest of group 3
		endcase
	end

	// ========================================================================
	// state machine and control word
	// ========================================================================

	always_comb begin : next_state
		state_nxt = state;
		unique case (state)
			S_FETCH: begin
				if (run) begin // opcode here is the live rom byte
					if (opcode == OP_HALT)
						state_nxt = S_HALT;
					else if (dec_imm)
						state_nxt = S_IMM;
					else
						state_nxt = S_EXEC;
				end
			end
			S_IMM:  state_nxt = S_EXEC;
			S_EXEC: state_nxt = S_FETCH;
			S_HALT: state_nxt = S_HALT; // only reset gets us out
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) state <= S_FETCH;
		else        state <= state_nxt;
	end

	always_comb begin : ctrl_word
		ctrl         = '0;
		ctrl.dst     = dec_dst;
		ctrl.src     = fld_src;
		ctrl.use_imm = dec_imm;
		ctrl.alu_op  = dec_op;
		unique case (state)
			S_FETCH: ctrl.fetch_op = run; // run low just holds everything
			S_IMM:   ctrl.fetch_imm = 1'b1;
			S_EXEC: begin
				ctrl.reg_we  = dec_reg_we; // the only state that writes
				ctrl.flag_we = dec_flag_we;
			end
			S_HALT: ;
		endcase
	end

	assign halted = (state == S_HALT);

endmodule

/* src/board_pkg.sv */
package board_pkg;

	// ========================================================================
	// seven segment display types
	// ========================================================================

	// bit 0 is segment a up to bit 6 for segment g, a lit segment is 0
	typedef logic [6:0] seg_t;

	// switch pair that picks which two registers get shown
	typedef logic [1:0] pair_sel_t;

	localparam pair_sel_t PAIR_AB = 2'd0;
	localparam pair_sel_t PAIR_CD = 2'd1;
	localparam pair_sel_t PAIR_EF = 2'd2; // F shows flags in its high nibble
	localparam pair_sel_t PAIR_HL = 2'd3;

	// hex3 and hex2 carry the first register, hex1 and hex0 the second
	typedef struct packed {
		seg_t hex3; // high nibble of first register
		seg_t hex2;
		seg_t hex1; // high nibble of second register
		seg_t hex0;
	} hex_t;

endpackage

/* src/cpu_pkg.sv */
package cpu_pkg;

	// ========================================================================
	// widths and basic types
	// ========================================================================

	localparam int DATA_W    = 8;  // the core is 8 bits wide everywhere
	localparam int ADDR_W    = 16; // program counter spans the full 64k map
	localparam int REG_IDX_W = 3;

	typedef logic [DATA_W-1:0]    data_t;
	typedef logic [ADDR_W-1:0]    addr_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// flags in the order they sit in F bits 7..4
	typedef struct packed {
		logic z; // result was zero
		logic n; // last op was a subtraction
		logic h; // half carry or half borrow
		logic c; // carry or borrow
	} flags_t;

	// ========================================================================
	// register codes and opcode fields
	// ========================================================================

	localparam reg_idx_t REG_B      = 3'd0;
	localparam reg_idx_t REG_C      = 3'd1;
	localparam reg_idx_t REG_D      = 3'd2;
	localparam reg_idx_t REG_E      = 3'd3;
	localparam reg_idx_t REG_H      = 3'd4;
	localparam reg_idx_t REG_L      = 3'd5;
	localparam reg_idx_t REG_HL_MEM = 3'd6; // memory through HL, not a register
	localparam reg_idx_t REG_A      = 3'd7;

	localparam data_t OP_NOP  = 8'h00;
	localparam data_t OP_HALT = 8'h76; // sits where LD (HL),(HL) would be

	localparam int FLD_GRP_LSB = 6; // opcode is gg_ddd_sss
	localparam int FLD_DST_LSB = 3;
	localparam int FLD_SRC_LSB = 0;

	localparam logic [1:0] GRP_MISC = 2'b00; // inc, dec and ld r,d8 live here
	localparam logic [1:0] GRP_LD   = 2'b01;
	localparam logic [1:0] GRP_ALU  = 2'b10;

	localparam reg_idx_t LO_INC    = 3'b100; // low field inside the misc group
	localparam reg_idx_t LO_DEC    = 3'b101;
	localparam reg_idx_t LO_LD_IMM = 3'b110;

	localparam reg_idx_t AOP_ADD = 3'b000; // middle field inside the alu group
	localparam reg_idx_t AOP_SUB = 3'b010;
	localparam reg_idx_t AOP_AND = 3'b100;
	localparam reg_idx_t AOP_XOR = 3'b101;
	localparam reg_idx_t AOP_OR  = 3'b110;

	// ========================================================================
	// control types
	// ========================================================================

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_XOR, ALU_OR, ALU_INC, ALU_DEC, ALU_PASS
	} alu_op_t;

	typedef enum logic [1:0] {S_FETCH, S_IMM, S_EXEC, S_HALT} seq_state_t;

	typedef struct packed {
		logic     fetch_op;  // latch opcode and bump pc
		logic     fetch_imm; // latch immediate and bump pc
		logic     reg_we;
		logic     flag_we;
		reg_idx_t dst;
		reg_idx_t src;
		logic     use_imm;   // operand b comes from the immediate
		alu_op_t  alu_op;
	} ctrl_t;

endpackage
